// ==== tb.f ====
rtl/snac_pkg.sv
rtl/snac_config.sv
rtl/frac_strobe_gen.sv
rtl/serial_latch_reader.sv
rtl/snac_pin_map.sv
rtl/snac_adapter_top.sv
bench/snac_properties.sv
bench/tb_snac.sv

// ==== Makefile ====
# Verilator build and run for the two-player pad adapter testbench

VERILATOR ?= verilator
TOP       ?= tb_snac
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
CLK_FREQ  ?= 8000000
SEED      ?= 39708
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Overridable: VERILATOR CLK_FREQ SEED VFLAGS SIM_ARGS OBJ_DIR"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GCLK_FREQ=$(CLK_FREQ) -GSEED=$(SEED) \
		-f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$($(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_snac.sv ====
// Testbench for the two-player NES/SNES pad adapter with pad models, frame checks and watchdog
`timescale 1ns/1ps

module tb_snac #(
    parameter int CLK_FREQ = 8_000_000,     // DUT clock in Hz
    parameter int SEED     = 39708          // Start value for $random
);

    localparam int CLK_PERIOD   = 10;                        // ns
    localparam int SLOW_STB     = CLK_FREQ / 200_000 + 1;    // Strobe spacing at compat rate
    localparam int FRAME_CYC    = (2 + 2 * 16) * SLOW_STB;   // Longest SNES frame
    localparam int WATCHDOG_CYC = 20 * FRAME_CYC + 4000;     // 20 slow frames plus slack

    logic                i_clk = 1'b0;
    logic                i_reset;
    snac_pkg::pad_type_t i_pad_type;
    snac_pkg::rate_t     i_rate;
    logic [7:4]          i_cart_bk0_in;
    logic [15:0]         o_p1_btn;
    logic [15:0]         o_p2_btn;
    logic                o_busy;
    logic                o_cart_bk0_dir;
    logic [7:6]          o_cart_bk1_out;     // 7 latch, 6 pad clock
    logic                o_cart_pin30_out;
    logic                o_cart_pin30_dir;
    logic                o_cart_pin31_dir;

    integer      seed = SEED;
    logic [15:0] pat1 = 16'hFFFF;            // Pad 1 wire pattern, 0 = pressed
    logic [15:0] pat2 = 16'hFFFF;
    logic [15:0] pad1_sr = 16'hFFFF;         // Pad 1 shift register, bit 0 on the wire
    logic [15:0] pad2_sr = 16'hFFFF;
    logic        clk_pin_q = 1'b0;           // Pad clock pin half a cycle ago

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    snac_adapter_top #(
        .CLK_FREQ         (CLK_FREQ)
    ) u_snac_adapter_top (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_pad_type       (i_pad_type),
        .i_rate           (i_rate),
        .i_cart_bk0_in    (i_cart_bk0_in),
        .o_p1_btn         (o_p1_btn),
        .o_p2_btn         (o_p2_btn),
        .o_busy           (o_busy),
        .o_cart_bk0_dir   (o_cart_bk0_dir),
        .o_cart_bk1_out   (o_cart_bk1_out),
        .o_cart_pin30_out (o_cart_pin30_out),
        .o_cart_pin30_dir (o_cart_pin30_dir),
        .o_cart_pin31_dir (o_cart_pin31_dir)
    );

    bind snac_adapter_top snac_properties #(
        .CLK_FREQ    (CLK_FREQ)
    ) u_snac_properties (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_pad_type  (i_pad_type),
        .i_rate      (i_rate),
        .i_busy      (o_busy),
        .i_p1_btn    (o_p1_btn),
        .i_p2_btn    (o_p2_btn),
        .i_bk0_dir   (o_cart_bk0_dir),
        .i_bk1_out   (o_cart_bk1_out),
        .i_pin30_out (o_cart_pin30_out),
        .i_pin30_dir (o_cart_pin30_dir),
        .i_pin31_dir (o_cart_pin31_dir)
    );

    // Two pads, updated on the falling edge so data is steady at the DUT's rising edge
    always @(negedge i_clk) begin
        if (o_cart_bk1_out[7]) begin
            pad1_sr <= pat1;                         // Latch high, pads capture buttons
            pad2_sr <= pat2;
        end else if (o_cart_bk1_out[6] && !clk_pin_q) begin
            pad1_sr <= {1'b1, pad1_sr[15:1]};        // Next button on each clock rise
            pad2_sr <= {1'b1, pad2_sr[15:1]};
        end
        clk_pin_q <= o_cart_bk1_out[6];
    end

    assign i_cart_bk0_in = {2'b11, pad2_sr[0], pad1_sr[0]};   // Spare pins pulled up

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            $display("ERROR: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // Everything the pads see and report is quiet
    task automatic check_idle();
        check_value("o_busy", 16'(o_busy), 16'h0000);
        check_value("o_p1_btn", o_p1_btn, 16'h0000);
        check_value("o_p2_btn", o_p2_btn, 16'h0000);
        check_value("o_cart_bk1_out", 16'(o_cart_bk1_out), 16'h0000);
        check_value("o_cart_pin30_out", 16'(o_cart_pin30_out), 16'h0000);
    endtask

    // One whole frame, from busy rising to the commit
    task automatic wait_frame();
        while (!o_busy) @(negedge i_clk);
        while (o_busy) @(negedge i_clk);
    endtask

    task automatic set_mode(input snac_pkg::pad_type_t t, input snac_pkg::rate_t r);
        i_pad_type = snac_pkg::PAD_DISABLED;         // Through idle, no frame is cut short
        repeat (4) @(negedge i_clk);
        i_rate     = r;
        i_pad_type = t;
        @(negedge i_clk);
    endtask

    task automatic run_frames(input int n, input bit nes);
        logic [31:0] rnd;
        logic [15:0] exp1;
        logic [15:0] exp2;
        for (int i = 0; i < n; i++) begin
            rnd  = $random(seed);
            pat1 = rnd[15:0];
            rnd  = $random(seed);
            pat2 = rnd[15:0];
            wait_frame();
            exp1 = ~pat1;                            // Pressed is low on the wire
            exp2 = ~pat2;
            if (nes) begin
                exp1[15:8] = 8'h00;                  // Only 8 bits per NES frame
                exp2[15:8] = 8'h00;
            end
            check_value("o_p1_btn", o_p1_btn, exp1);
            check_value("o_p2_btn", o_p2_btn, exp2);
        end
    endtask

    // Bound port checks end the run too
    always @(negedge i_clk) begin
        if (u_snac_adapter_top.u_snac_properties.any_fail) begin
            $display("A bound property on the DUT ports failed");
            abort_run();
        end
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Timeout, frames did not finish within %0d cycles", WATCHDOG_CYC);
        abort_run();
    end

    initial begin
        i_reset    = 1'b1;
        i_pad_type = snac_pkg::PAD_DISABLED;
        i_rate     = snac_pkg::RATE_COMPAT;
        repeat (4) @(negedge i_clk);
        i_reset = 1'b0;
        check_idle();
        repeat (50) @(negedge i_clk);                // Disabled pad stays silent
        check_idle();

        // Latch width at every rate
        for (int r = 0; r < 4; r++) begin
            set_mode(snac_pkg::PAD_SNES, snac_pkg::rate_t'(r[1:0]));
            run_frames(2, 1'b0);
        end

        set_mode(snac_pkg::PAD_SNES, snac_pkg::RATE_NORMAL);
        run_frames(4, 1'b0);

        set_mode(snac_pkg::PAD_NES, snac_pkg::RATE_FAST);
        run_frames(4, 1'b1);

        // Switch off in the middle of a SNES frame
        set_mode(snac_pkg::PAD_SNES, snac_pkg::RATE_NORMAL);
        while (!o_busy) @(negedge i_clk);
        repeat (CLK_FREQ / 40_000) @(negedge i_clk);     // About ten strobes in
        if (!o_busy) begin
            $display("Frame ended before the pad type was switched off");
            abort_run();
        end
        i_pad_type = snac_pkg::PAD_DISABLED;
        repeat (3) @(negedge i_clk);
        check_idle();
        set_mode(snac_pkg::PAD_SNES, snac_pkg::RATE_NORMAL);
        run_frames(2, 1'b0);

        repeat (10) @(negedge i_clk);
        if (u_snac_adapter_top.u_snac_properties.any_fail) begin
            abort_run();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// ==== bench/snac_properties.sv ====
// Bound checks on the adapter ports: pin directions, idle outputs, latch width, clock count
`timescale 1ns/1ps

module snac_properties #(
    parameter int CLK_FREQ = 50_000_000     // DUT clock in Hz
) (
    input logic                i_clk,
    input logic                i_reset,
    input snac_pkg::pad_type_t i_pad_type,
    input snac_pkg::rate_t     i_rate,
    input logic                i_busy,
    input logic [15:0]         i_p1_btn,
    input logic [15:0]         i_p2_btn,
    input logic                i_bk0_dir,
    input logic [7:6]          i_bk1_out,    // 7 latch, 6 pad clock
    input logic                i_pin30_out,
    input logic                i_pin30_dir,
    input logic                i_pin31_dir
);

    logic pad_on;                   // NES or SNES selected
    logic latch_q;
    logic clk_q;
    logic armed;                    // A latch seen since the pad came on
    int   hi_cnt;                   // Cycles the latch pin has been high
    int   rise_cnt;                 // Clock pin rises since the last latch
    int   stb_hz;                   // Twice the poll frequency
    int   lo_w;
    int   hi_w;
    int   exp_rises;
    logic bad_dir = 1'b0;
    logic bad_mirror = 1'b0;
    logic bad_idle = 1'b0;
    logic bad_width = 1'b0;
    logic bad_rises = 1'b0;
    logic any_fail;

    assign pad_on = (i_pad_type == snac_pkg::PAD_NES) || (i_pad_type == snac_pkg::PAD_SNES);
    assign any_fail = bad_dir | bad_mirror | bad_idle | bad_width | bad_rises;

    always_comb begin
        case (i_rate)
            snac_pkg::RATE_COMPAT: stb_hz = 200_000;
            snac_pkg::RATE_NORMAL: stb_hz = 400_000;
            snac_pkg::RATE_FAST:   stb_hz = 800_000;
            default:               stb_hz = 2_000_000;
        endcase
        lo_w      = CLK_FREQ / stb_hz;                  // Floor of the strobe spacing
        hi_w      = (CLK_FREQ + stb_hz - 1) / stb_hz;   // Ceiling
        exp_rises = (i_pad_type == snac_pkg::PAD_NES) ? 8 : 16;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            latch_q  <= 1'b0;
            clk_q    <= 1'b0;
            armed    <= 1'b0;
            hi_cnt   <= 0;
            rise_cnt <= 0;
        end else begin
            latch_q <= i_bk1_out[7];
            clk_q   <= i_bk1_out[6];
            hi_cnt  <= i_bk1_out[7] ? hi_cnt + 1 : 0;
            if (i_bk1_out[7] && !latch_q) rise_cnt <= 0;           // New frame
            else if (i_bk1_out[6] && !clk_q) rise_cnt <= rise_cnt + 1;
            if (!pad_on) armed <= 1'b0;
            else if (i_bk1_out[7] && !latch_q) armed <= 1'b1;
        end
    end

    a_dir_fixed: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_bk0_dir && i_pin30_dir && !i_pin31_dir)
        else begin $error("Cart pin direction changed"); bad_dir = 1'b1; end

    a_pin30_copy: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pin30_out == i_bk1_out[6])
        else begin $error("Pin 30 differs from bank 1 clock"); bad_mirror = 1'b1; end

    // Three cycles of pipeline after the type goes off
    a_idle_off: assert property (@(posedge i_clk) disable iff (i_reset)
        !pad_on && !$past(pad_on, 1) && !$past(pad_on, 2) && !$past(pad_on, 3) |->
        !i_busy && i_p1_btn == 16'h0 && i_p2_btn == 16'h0 && i_bk1_out == 2'b00)
        else begin $error("Outputs active while pad disabled"); bad_idle = 1'b1; end

    a_latch_width: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_bk1_out[7] && latch_q && pad_on |-> hi_cnt >= lo_w && hi_cnt <= hi_w)
        else begin $error("Latch high for %0d cycles", hi_cnt); bad_width = 1'b1; end

    a_clock_count: assert property (@(posedge i_clk) disable iff (i_reset)
        i_bk1_out[7] && !latch_q && armed |-> rise_cnt == exp_rises)
        else begin $error("Saw %0d pad clock rises", rise_cnt); bad_rises = 1'b1; end

endmodule

// ==== rtl/snac_adapter_top.sv ====
// Two-player NES/SNES pad adapter top level for the cartridge port
`timescale 1ns/1ps

module snac_adapter_top #(
    parameter int CLK_FREQ = 50_000_000     // At least 8x the fastest poll rate
) (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  snac_pkg::pad_type_t        i_pad_type,
    input  snac_pkg::rate_t            i_rate,
    input  logic [7:4]                 i_cart_bk0_in,
    output logic [snac_pkg::BTN_W-1:0] o_p1_btn,       // Player 1 active-high buttons
    output logic [snac_pkg::BTN_W-1:0] o_p2_btn,       // Player 2 active-high buttons
    output logic                       o_busy,         // Falls when a frame lands
    output logic                       o_cart_bk0_dir,
    output logic [7:6]                 o_cart_bk1_out,
    output logic                       o_cart_pin30_out,
    output logic                       o_cart_pin30_dir,
    output logic                       o_cart_pin31_dir
);

    logic [snac_pkg::STEP_W-1:0] step;      // Divider increment
    logic                        enable;    // Serial-latch pad selected
    logic                        nes_mode;
    logic                        div_reset;
    logic                        stb;       // Polling strobe
    logic                        latch;
    logic                        pad_clk;
    logic                        dat1;
    logic                        dat2;

    snac_config #(
        .CLK_FREQ    (CLK_FREQ)
    ) u_snac_config (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_pad_type  (i_pad_type),
        .i_rate      (i_rate),
        .o_step      (step),
        .o_enable    (enable),
        .o_nes_mode  (nes_mode),
        .o_div_reset (div_reset)
    );

    frac_strobe_gen u_frac_strobe_gen (
        .i_clk       (i_clk),
        .i_div_reset (div_reset),     // Restart on any settings change
        .i_step      (step),
        .o_stb       (stb)
    );

    serial_latch_reader u_serial_latch_reader (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_enable   (enable),
        .i_nes_mode (nes_mode),
        .i_stb      (stb),
        .i_dat1     (dat1),
        .i_dat2     (dat2),
        .o_latch    (latch),
        .o_pad_clk  (pad_clk),
        .o_busy     (o_busy),
        .o_p1_btn   (o_p1_btn),
        .o_p2_btn   (o_p2_btn)
    );

    snac_pin_map u_snac_pin_map (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_latch          (latch),
        .i_pad_clk        (pad_clk),
        .o_dat1           (dat1),
        .o_dat2           (dat2),
        .o_cart_bk0_dir   (o_cart_bk0_dir),
        .i_cart_bk0_in    (i_cart_bk0_in),
        .o_cart_bk1_out   (o_cart_bk1_out),
        .o_cart_pin30_out (o_cart_pin30_out),
        .o_cart_pin30_dir (o_cart_pin30_dir),
        .o_cart_pin31_dir (o_cart_pin31_dir)
    );

endmodule

// ==== rtl/snac_pin_map.sv ====
// Registered cartridge-port pin routing for the serial-latch pad harness
`timescale 1ns/1ps

module snac_pin_map (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_latch,           // Latch from the reader
    input  logic       i_pad_clk,         // Pad clock from the reader
    output logic       o_dat1,            // Player 1 data toward the reader
    output logic       o_dat2,            // Player 2 data toward the reader
    output logic       o_cart_bk0_dir,    // Bank 0 direction
    input  logic [7:4] i_cart_bk0_in,     // Bank 0 pins as inputs
    output logic [7:6] o_cart_bk1_out,    // Bank 1 pins as outputs
    output logic       o_cart_pin30_out,  // Second pad clock
    output logic       o_cart_pin30_dir,
    output logic       o_cart_pin31_dir
);

    // Port layout
    //   bank1[6]  pad clock         (USB D-)
    //   bank1[7]  latch             (USB D+)
    //   pin30     pad clock copy    (GND_D pair)
    //   bank0[4]  player 1 data     (RX-)
    //   bank0[5]  player 2 data     (TX+)
    // Bank 0 bits 7 and 6 carry no pad signal in this harness

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_cart_bk1_out   <= 2'b00;
            o_cart_pin30_out <= 1'b0;
            o_dat1           <= 1'b0;
            o_dat2           <= 1'b0;
        end else begin
            o_cart_bk1_out   <= {i_latch, i_pad_clk};  // One cycle to the pins
            o_cart_pin30_out <= i_pad_clk;             // Same edge as bank 1 clock
            o_dat1           <= i_cart_bk0_in[4];      // Resync data from the pads
            o_dat2           <= i_cart_bk0_in[5];
        end
    end

    // Directions never change
    assign o_cart_bk0_dir   = 1'b0;   // Bank 0 input
    assign o_cart_pin30_dir = 1'b1;   // Pin 30 output
    assign o_cart_pin31_dir = 1'b0;   // Pin 31 left as input

    // Clock edge out to sampled data back is 3 cycles at most
    // reader reg, pin reg, then input reg

endmodule

// ==== rtl/serial_latch_reader.sv ====
// Latch and clock sequencer with two parallel data shifters for NES and SNES pads
`timescale 1ns/1ps

module serial_latch_reader (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_enable,    // Pad type is NES or SNES
    input  logic                       i_nes_mode,  // 8 bits per frame when set
    input  logic                       i_stb,       // Polling strobe, twice poll rate
    input  logic                       i_dat1,      // Player 1 serial data
    input  logic                       i_dat2,      // Player 2 serial data
    output logic                       o_latch,     // Shared latch line
    output logic                       o_pad_clk,   // Shared clock line
    output logic                       o_busy,      // Frame in progress
    output logic [snac_pkg::BTN_W-1:0] o_p1_btn,    // Active-high buttons
    output logic [snac_pkg::BTN_W-1:0] o_p2_btn
);

    localparam int CNT_W = $clog2(snac_pkg::SNES_BITS);

    // Frame phases, one strobe moves at most one step
    typedef enum logic [1:0] {
        PH_IDLE,      // Waiting for the strobe that starts a frame
        PH_LATCH,     // Latch high, pads capture their buttons
        PH_SAMPLE,    // Next strobe samples data and drops the clock
        PH_RISE       // Next strobe raises the clock and shifts the pads
    } phase_t;

    phase_t                     phase;
    logic [CNT_W-1:0]           bit_cnt;    // Index of the bit being read
    logic [CNT_W-1:0]           last_bit;   // Final index for this pad type
    logic [snac_pkg::BTN_W-1:0] sr1;        // Player 1 bits gathered so far
    logic [snac_pkg::BTN_W-1:0] sr2;        // Player 2 bits gathered so far

    assign last_bit = i_nes_mode ? CNT_W'(snac_pkg::NES_BITS - 1)
                                 : CNT_W'(snac_pkg::SNES_BITS - 1);

    always_ff @(posedge i_clk) begin
        if (i_reset || !i_enable) begin
            // Disable drops everything straight back to idle
            phase     <= PH_IDLE;
            bit_cnt   <= '0;
            o_latch   <= 1'b0;
            o_pad_clk <= 1'b0;
            o_busy    <= 1'b0;
            o_p1_btn  <= '0;
            o_p2_btn  <= '0;
            sr1       <= '0;
            sr2       <= '0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    o_pad_clk <= 1'b1;              // Clock idles high
                    if (i_stb) begin
                        o_latch <= 1'b1;
                        o_busy  <= 1'b1;
                        sr1     <= '0;              // Unused upper bits read as 0
                        sr2     <= '0;
                        phase   <= PH_LATCH;
                    end
                end
                PH_LATCH: begin
                    if (i_stb) begin
                        o_latch <= 1'b0;            // Pads now present bit 0
                        bit_cnt <= '0;
                        phase   <= PH_SAMPLE;
                    end
                end
                PH_SAMPLE: begin
                    if (i_stb) begin
                        // Pads pull low for a pressed button
                        sr1[bit_cnt] <= ~i_dat1;
                        sr2[bit_cnt] <= ~i_dat2;
                        o_pad_clk    <= 1'b0;
                        phase        <= PH_RISE;
                    end
                end
                PH_RISE: begin
                    if (i_stb) begin
                        o_pad_clk <= 1'b1;          // Rising edge advances both pads
                        if (bit_cnt == last_bit) begin
                            o_p1_btn <= sr1;        // Commit whole frame at once
                            o_p2_btn <= sr2;
                            o_busy   <= 1'b0;       // Marks end of frame
                            phase    <= PH_IDLE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            phase   <= PH_SAMPLE;
                        end
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // Frame takes 2 + 2N strobes
    // latch up, latch down, then N pairs of sample-low and rise

endmodule

// ==== rtl/frac_strobe_gen.sv ====
// Fractional phase-accumulator divider producing the polling strobe
`timescale 1ns/1ps

module frac_strobe_gen (
    input  logic                        i_clk,
    input  logic                        i_div_reset,  // Clears phase and strobe
    input  logic [snac_pkg::STEP_W-1:0] i_step,       // Phase increment per cycle
    output logic                        o_stb         // One-cycle polling strobe
);

    logic [snac_pkg::STEP_W-1:0] acc;   // Phase accumulator
    logic [snac_pkg::STEP_W:0]   sum;   // Next phase with carry on top

    // Carry out of the add marks one strobe period
    assign sum = {1'b0, acc} + {1'b0, i_step};

    always_ff @(posedge i_clk) begin
        if (i_div_reset) begin
            acc   <= '0;
            o_stb <= 1'b0;                          // No pulse right after a restart
        end else begin
            acc   <= sum[snac_pkg::STEP_W-1:0];     // Wraps modulo 2^32
            o_stb <= sum[snac_pkg::STEP_W];         // Registered carry
        end
    end

    // Spacing alternates between floor and ceiling of 2^32 / step,
    // so the average rate is exact to within one step LSB
    // A zero step never carries and the strobe stays low

endmodule

// ==== rtl/snac_config.sv ====
// Settings register with change detection, enable decode and poll step selection
`timescale 1ns/1ps

module snac_config #(
    parameter int CLK_FREQ = 50_000_000     // System clock in Hz
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  snac_pkg::pad_type_t           i_pad_type,
    input  snac_pkg::rate_t               i_rate,
    output logic [snac_pkg::STEP_W-1:0]   o_step,      // Divider step, zero when disabled
    output logic                          o_enable,    // NES or SNES selected
    output logic                          o_nes_mode,  // 8-bit frame instead of 16
    output logic                          o_div_reset  // Restart the divider
);

    // Step per rate code, all computed at elaboration
    localparam logic [snac_pkg::STEP_W-1:0] STEP_TAB [4] = '{
        snac_pkg::poll_step(CLK_FREQ, snac_pkg::POLL_FREQ[0]),
        snac_pkg::poll_step(CLK_FREQ, snac_pkg::POLL_FREQ[1]),
        snac_pkg::poll_step(CLK_FREQ, snac_pkg::POLL_FREQ[2]),
        snac_pkg::poll_step(CLK_FREQ, snac_pkg::POLL_FREQ[3])
    };

    snac_pkg::pad_type_t          pad_type_r;  // Settings as last seen
    snac_pkg::rate_t              rate_r;
    logic                         changed;     // Any setting differs from register
    logic                         pad_valid;   // Incoming type is a serial-latch pad

    assign changed   = (i_pad_type != pad_type_r) || (i_rate != rate_r);
    assign pad_valid = (i_pad_type == snac_pkg::PAD_NES) ||
                       (i_pad_type == snac_pkg::PAD_SNES);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pad_type_r  <= snac_pkg::PAD_DISABLED;
            rate_r      <= snac_pkg::RATE_COMPAT;
            o_step      <= '0;
            o_div_reset <= 1'b1;               // Hold divider cleared through reset
        end else begin
            pad_type_r  <= i_pad_type;
            rate_r      <= i_rate;
            o_div_reset <= changed;            // One cycle after a settings edit
            // New step lands together with the divider restart
            o_step      <= pad_valid ? STEP_TAB[i_rate] : '0;
        end
    end

    // Decoded from the registered type so they line up with o_step
    assign o_enable   = (pad_type_r == snac_pkg::PAD_NES) ||
                        (pad_type_r == snac_pkg::PAD_SNES);
    assign o_nes_mode = (pad_type_r == snac_pkg::PAD_NES);

endmodule

// ==== rtl/snac_pkg.sv ====
// Pad type codes, sample rate codes, poll frequencies, widths and the divider step function
package snac_pkg;

    // Pad types on the serial-latch port, unlisted codes behave as disabled
    typedef enum logic [4:0] {
        PAD_DISABLED = 5'd0,
        PAD_NES      = 5'd2,                // 8 bits per frame
        PAD_SNES     = 5'd3                 // 16 bits per frame
    } pad_type_t;

    // Sample rate selection
    typedef enum logic [1:0] {
        RATE_COMPAT = 2'd0,                 // Slowest, for long cables
        RATE_NORMAL = 2'd1,
        RATE_FAST   = 2'd2,
        RATE_TURBO  = 2'd3
    } rate_t;

    localparam int STEP_W = 32;             // Phase accumulator width
    localparam int BTN_W  = 16;             // Button word width

    localparam int NES_BITS  = 8;           // Bits shifted per NES frame
    localparam int SNES_BITS = 16;          // Bits shifted per SNES frame

    // Poll frequency in Hz per rate code
    localparam logic [31:0] POLL_FREQ [4] = '{
        32'd100_000,                        // RATE_COMPAT
        32'd200_000,                        // RATE_NORMAL
        32'd400_000,                        // RATE_FAST
        32'd1_000_000                       // RATE_TURBO
    };

    // Accumulator step for a strobe at twice the poll frequency
    // Step = 2^32 * 2 * freq / clk_freq, truncated
    function automatic logic [STEP_W-1:0] poll_step(
        input logic [63:0] clk_freq,
        input logic [31:0] freq
    );
        logic [63:0] num;
        logic [63:0] quo;
        num = {32'd0, freq} << (STEP_W + 1);   // Times 2^32 and times 2
        quo = num / clk_freq;
        return quo[STEP_W-1:0];
    endfunction

endpackage
